// ==== include/csr_defines.svh ====
/*
 * Machine-mode CSR block constants
 * Widths, CSR addresses, identity values, reset values and bit masks
 */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_N_IRQ           16

// ----------------------------------------
// CSR addresses
`define CSR_A_MVENDORID     12'hf11
`define CSR_A_MARCHID       12'hf12
`define CSR_A_MIMPID        12'hf13
`define CSR_A_MHARTID       12'hf14
`define CSR_A_MSTATUS       12'h300
`define CSR_A_MISA          12'h301
`define CSR_A_MIE           12'h304
`define CSR_A_MTVEC         12'h305
`define CSR_A_MCOUNTINHIBIT 12'h320
`define CSR_A_MSCRATCH      12'h340
`define CSR_A_MEPC          12'h341
`define CSR_A_MCAUSE        12'h342
`define CSR_A_MTVAL         12'h343
`define CSR_A_MIP           12'h344
`define CSR_A_MCYCLE        12'hb00
`define CSR_A_MINSTRET      12'hb02
`define CSR_A_MCYCLEH       12'hb80
`define CSR_A_MINSTRETH     12'hb82

// ----------------------------------------
// Identity and reset values
`define CSR_MVENDORID_VAL   32'h0000_0000 // Non-commercial part
`define CSR_MARCHID_VAL     32'h0000_001b
`define CSR_MIMPID_VAL      32'h0000_0001
`define CSR_MISA_VAL        32'h4000_1104 // MXL=1, M, I, C
`define CSR_MTVEC_INIT      32'h0000_0000
`define CSR_MTVEC_WMASK     32'hffff_fffd // Base plus mode bit 0, bit 1 tied low
`define CSR_MIE_RSVD_MASK   32'h0000_f777

`endif

// ==== hw/csr_pkg.sv ====
/*
 * CSR block shared types
 * Access request, register selects, exception codes, trap cause
 * and the common write/set/clear update rule
 */
package csr_pkg;

`include "csr_defines.svh"

	// Write kind from the CSR instruction
	typedef enum logic [1:0] {
		wt_write = 2'd1,
		wt_set   = 2'd2,
		wt_clear = 2'd3
	} csr_wtype_t;

	// One access from the core, 48 bits
	typedef struct packed {
		logic [`CSR_ADDR_W-1:0] addr;
		logic [`CSR_XLEN-1:0]   wdata;
		csr_wtype_t             wtype;
		logic                   wen;
		logic                   ren;
	} csr_req_t;

	// One select bit per implemented register
	typedef struct packed {
		logic mstatus;
		logic mscratch;
		logic mtvec;
		logic mepc;
		logic mcause;
		logic mie;
		logic mcycle;
		logic mcycleh;
		logic minstret;
		logic minstreth;
		logic mcountinhibit;
		logic ident;         // Read-only and hardwired group
		logic mip;
	} csr_sel_t;

	typedef enum logic [3:0] {
		exc_illegal    = 4'd2,
		exc_breakpoint = 4'd3,
		exc_mret       = 4'ha, // Reserved code, marks trap return
		exc_ecall      = 4'd11,
		exc_none       = 4'hf
	} except_t;

	typedef struct packed {
		logic       is_irq;
		logic [4:0] code;
	} trap_cause_t;

	// Result of a CSR write of any kind against the previous value
	function automatic logic [`CSR_XLEN-1:0] csr_update(
		input logic [`CSR_XLEN-1:0] prev,
		input csr_wtype_t           wtype,
		input logic [`CSR_XLEN-1:0] wdata
	);
		case (wtype)
			wt_set:   return prev | wdata;
			wt_clear: return prev & ~wdata;
			default:  return wdata;
		endcase
	endfunction

endpackage

// ==== hw/csr_decode.sv ====
/*
 * CSR address decoder
 * One-hot register select, identity constants, read-data merge
 * and illegal access detection
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_decode (
	input  csr_pkg::csr_req_t     req,
	input  logic [`CSR_XLEN-1:0]  trap_rdata, // Already gated by sel
	input  logic [`CSR_XLEN-1:0]  ctr_rdata,  // Already gated by sel
	input  logic [`CSR_XLEN-1:0]  mip,
	output csr_pkg::csr_sel_t     sel,
	output logic                  wr_en,
	output logic [`CSR_XLEN-1:0]  rdata,
	output logic                  illegal
);

	logic [`CSR_XLEN-1:0] ident_rdata;
	logic                 ident_ro;    // Address is a read-only identity register
	logic                 decode_hit;

	// ----------------------------------------
	// Address decode
	always_comb begin
		sel         = '0;
		ident_rdata = '0;
		ident_ro    = 1'b0;
		case (req.addr)
			`CSR_A_MSTATUS:       sel.mstatus       = 1'b1;
			`CSR_A_MSCRATCH:      sel.mscratch      = 1'b1;
			`CSR_A_MTVEC:         sel.mtvec         = 1'b1;
			`CSR_A_MEPC:          sel.mepc          = 1'b1;
			`CSR_A_MCAUSE:        sel.mcause        = 1'b1;
			`CSR_A_MIE:           sel.mie           = 1'b1;
			`CSR_A_MIP:           sel.mip           = 1'b1;
			`CSR_A_MCYCLE:        sel.mcycle        = 1'b1;
			`CSR_A_MCYCLEH:       sel.mcycleh       = 1'b1;
			`CSR_A_MINSTRET:      sel.minstret      = 1'b1;
			`CSR_A_MINSTRETH:     sel.minstreth     = 1'b1;
			`CSR_A_MCOUNTINHIBIT: sel.mcountinhibit = 1'b1;
			`CSR_A_MISA: begin
				sel.ident   = 1'b1;        // WARL, writes dropped silently
				ident_rdata = `CSR_MISA_VAL;
			end
			`CSR_A_MTVAL: begin
				sel.ident = 1'b1;          // Hardwired zero, writes ignored
			end
			`CSR_A_MVENDORID: begin
				sel.ident   = 1'b1;
				ident_ro    = 1'b1;
				ident_rdata = `CSR_MVENDORID_VAL;
			end
			`CSR_A_MARCHID: begin
				sel.ident   = 1'b1;
				ident_ro    = 1'b1;
				ident_rdata = `CSR_MARCHID_VAL;
			end
			`CSR_A_MIMPID: begin
				sel.ident   = 1'b1;
				ident_ro    = 1'b1;
				ident_rdata = `CSR_MIMPID_VAL;
			end
			`CSR_A_MHARTID: begin
				sel.ident = 1'b1;          // Single hart, always zero
				ident_ro  = 1'b1;
			end
			default: ;                     // hpm and friends fall out as illegal
		endcase
	end

	assign decode_hit = |sel;

	// Unmapped address, or a write to a read-only identity register
	assign illegal = (req.ren || req.wen) && (!decode_hit || (req.wen && ident_ro));
	assign wr_en   = req.wen && !illegal;

	// Each source is zero unless selected, so a plain OR merges them
	assign rdata = trap_rdata | ctr_rdata | ident_rdata | ({`CSR_XLEN{sel.mip}} & mip);

	// Read merge relies on at most one source being live
	a_sel_onehot0: assert final ($onehot0(sel));

endmodule

// ==== hw/csr_trap_regs.sv ====
/*
 * Trap state registers
 * mstatus enable stack, mscratch, mtvec, mepc, mcause and mie,
 * with software access and trap entry/return updates
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_trap_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  csr_pkg::csr_req_t     req,
	input  csr_pkg::csr_sel_t     sel,
	input  logic                  wr_en,
	input  logic                  trap_fire,
	input  csr_pkg::trap_cause_t  trap_cause,
	input  csr_pkg::except_t      except,
	input  logic [`CSR_XLEN-1:0]  mepc_in,
	output logic [`CSR_XLEN-1:0]  trap_rdata,
	output logic                  mstatus_mie,
	output logic [`CSR_XLEN-1:0]  mie,
	output logic [`CSR_XLEN-1:0]  mtvec,
	output logic [`CSR_XLEN-1:0]  mepc
);

	import csr_pkg::*;

	logic                 mstatus_mpie;
	logic [`CSR_XLEN-1:0] mscratch;
	trap_cause_t          mcause_q;
	logic [`CSR_XLEN-1:0] mstatus_word;
	logic [`CSR_XLEN-1:0] mcause_word;
	logic [`CSR_XLEN-1:0] upd;          // Software result for the selected register
	logic                 sw_wr;        // Software write that survives a trap
	logic                 is_mret;

	assign is_mret = except == exc_mret;
	assign sw_wr   = wr_en && !trap_fire; // Trap wins the edge

	// ----------------------------------------
	// Read views
	assign mstatus_word = {19'h0, 2'b11, 3'h0, mstatus_mpie, 3'h0, mstatus_mie, 3'h0}; // MPP=M
	assign mcause_word  = {mcause_q.is_irq, 26'h0, mcause_q.code};

	always_comb begin
		trap_rdata = ({`CSR_XLEN{sel.mstatus}}  & mstatus_word)
		           | ({`CSR_XLEN{sel.mscratch}} & mscratch)
		           | ({`CSR_XLEN{sel.mtvec}}    & mtvec)
		           | ({`CSR_XLEN{sel.mepc}}     & mepc)
		           | ({`CSR_XLEN{sel.mcause}}   & mcause_word)
		           | ({`CSR_XLEN{sel.mie}}      & mie);
	end

	// sel is one-hot, so the read word is the previous value of the target
	assign upd = csr_update(trap_rdata, req.wtype, req.wdata);

	// ----------------------------------------
	// Control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mtvec        <= `CSR_MTVEC_INIT;
			mie          <= '0;
			mcause_q     <= '0;
		end else begin
			if (trap_fire && is_mret) begin
				mstatus_mie  <= mstatus_mpie; // Pop the enable stack
				mstatus_mpie <= 1'b1;
			end else if (trap_fire) begin
				mstatus_mpie <= mstatus_mie;  // Push, interrupts off in handler
				mstatus_mie  <= 1'b0;
				mcause_q     <= trap_cause;
			end else if (sw_wr && sel.mstatus) begin
				mstatus_mpie <= upd[7];
				mstatus_mie  <= upd[3];
			end else if (sw_wr && sel.mcause) begin
				mcause_q.is_irq <= upd[31];
				mcause_q.code   <= upd[4:0];
			end
			if (sw_wr && sel.mtvec)
				mtvec <= upd & `CSR_MTVEC_WMASK;
			if (sw_wr && sel.mie)
				mie <= upd & ~`CSR_MIE_RSVD_MASK; // Reserved enables stay zero
		end
	end

	// ----------------------------------------
	// Payload registers
	always_ff @(posedge clk) begin
		if (trap_fire && !is_mret)
			mepc <= mepc_in & ~32'h1;          // Halfword aligned
		else if (sw_wr && sel.mepc)
			mepc <= upd & ~32'h1;
		if (sw_wr && sel.mscratch)
			mscratch <= upd;
	end

	// Trap entry state must come from the trap, not a same-cycle CSR write
	a_trap_wins: assert property (@(posedge clk) disable iff (!rst_n)
		trap_fire && !is_mret |=>
			(mepc == ($past(mepc_in) & ~32'h1)) && (mcause_q == $past(trap_cause)));

endmodule

// ==== hw/csr_counters.sv ====
/*
 * Cycle and retired-instruction counters
 * Two 64-bit counters written by 32-bit halves, plus mcountinhibit
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_counters (
	input  logic                  clk,
	input  logic                  rst_n,
	input  csr_pkg::csr_req_t     req,
	input  csr_pkg::csr_sel_t     sel,
	input  logic                  wr_en,
	input  logic                  instr_ret,
	output logic [`CSR_XLEN-1:0]  ctr_rdata
);

	import csr_pkg::*;

	logic [2*`CSR_XLEN-1:0] mcycle;
	logic [2*`CSR_XLEN-1:0] minstret;
	logic [2*`CSR_XLEN-1:0] mcycle_nxt;
	logic [2*`CSR_XLEN-1:0] minstret_nxt;
	logic                   inhibit_cy;   // mcountinhibit.CY, bit 0
	logic                   inhibit_ir;   // mcountinhibit.IR, bit 2
	logic [`CSR_XLEN-1:0]   upd;

	// ----------------------------------------
	// Read port
	always_comb begin
		ctr_rdata = ({`CSR_XLEN{sel.mcycle}}        & mcycle[31:0])
		          | ({`CSR_XLEN{sel.mcycleh}}       & mcycle[63:32])
		          | ({`CSR_XLEN{sel.minstret}}      & minstret[31:0])
		          | ({`CSR_XLEN{sel.minstreth}}     & minstret[63:32])
		          | ({`CSR_XLEN{sel.mcountinhibit}} & {29'h0, inhibit_ir, 1'b0, inhibit_cy});
	end

	assign upd = csr_update(ctr_rdata, req.wtype, req.wdata);

	// Step first, then let a software write replace its half
	always_comb begin
		mcycle_nxt   = inhibit_cy ? mcycle : mcycle + 64'd1;
		minstret_nxt = (inhibit_ir || !instr_ret) ? minstret : minstret + 64'd1;
		if (wr_en && sel.mcycle)
			mcycle_nxt[31:0] = upd;
		if (wr_en && sel.mcycleh)
			mcycle_nxt[63:32] = upd;
		if (wr_en && sel.minstret)
			minstret_nxt[31:0] = upd;
		if (wr_en && sel.minstreth)
			minstret_nxt[63:32] = upd;
	end

	// ----------------------------------------
	// State
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcycle     <= '0;
			minstret   <= '0;
			inhibit_cy <= 1'b0; // Counting from reset
			inhibit_ir <= 1'b0;
		end else begin
			mcycle   <= mcycle_nxt;
			minstret <= minstret_nxt;
			if (wr_en && sel.mcountinhibit) begin
				inhibit_ir <= upd[2];
				inhibit_cy <= upd[0];
			end
		end
	end

endmodule

// ==== hw/csr_irq_ctrl.sv ====
/*
 * Interrupt and trap request control
 * Synchronises external IRQs into mip, picks the winning line and
 * forms the trap request, target address and cause
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_irq_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`CSR_N_IRQ-1:0]  irq,
	input  logic                   delay_irq_entry,
	input  csr_pkg::except_t       except,
	input  logic                   trap_enter_rdy,
	input  logic                   mstatus_mie,
	input  logic [`CSR_XLEN-1:0]   mie,
	input  logic [`CSR_XLEN-1:0]   mtvec,
	input  logic [`CSR_XLEN-1:0]   mepc,
	output logic [`CSR_XLEN-1:0]   mip,
	output logic [`CSR_XLEN-1:0]   trap_addr,
	output logic                   trap_is_irq,
	output logic                   trap_enter_vld,
	output logic                   trap_fire,
	output csr_pkg::trap_cause_t   trap_cause
);

	import csr_pkg::*;

	logic [`CSR_N_IRQ-1:0] irq_q;
	logic [`CSR_N_IRQ-1:0] irq_act;   // Pending and individually enabled
	logic [3:0]            irq_num;
	logic                  irq_any;
	logic                  exc_any;
	logic                  is_mret;
	logic [`CSR_XLEN-1:0]  vec_offs;

	// ----------------------------------------
	// Sampling and pending bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq_q <= '0;
		else
			irq_q <= irq;
	end

	// Per-line bits high, global external pending at 11, timer/software stay 0
	assign mip = {irq_q, 4'h0, |irq_q, 11'h0};

	assign irq_act = irq_q & mie[31:16] & {`CSR_N_IRQ{mie[11]}};
	assign irq_any = |irq_act && mstatus_mie && !delay_irq_entry;

	// Lowest numbered line wins
	always_comb begin
		irq_num = '0;
		for (int i = `CSR_N_IRQ-1; i >= 0; i--) begin
			if (irq_act[i])
				irq_num = i[3:0];
		end
	end

	// ----------------------------------------
	// Trap request
	assign exc_any = except != exc_none;   // mret counts as an exception here
	assign is_mret = except == exc_mret;

	assign trap_enter_vld = exc_any || irq_any;
	assign trap_is_irq    = !exc_any;
	assign trap_fire      = trap_enter_vld && trap_enter_rdy;

	assign trap_cause.is_irq = !exc_any;
	assign trap_cause.code   = exc_any ? {1'b0, except} : {1'b1, irq_num}; // IRQ k is 16+k

	// Vectored mode only offsets interrupts
	assign vec_offs  = (mtvec[0] && !exc_any) ? {25'h0, 1'b1, irq_num, 2'b00} : '0;
	assign trap_addr = is_mret ? mepc : {mtvec[31:2], 2'b00} + vec_offs;

	// Return jumps back to the saved PC, never to the vector table
	a_mret_target: assert property (@(posedge clk) disable iff (!rst_n)
		trap_fire && is_mret |-> (trap_addr == mepc) && !trap_is_irq);

endmodule

// ==== hw/csr_top.sv ====
/*
 * Machine-mode CSR block top level
 * Connects decoder, trap registers, counters and interrupt control
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  csr_pkg::csr_req_t      req,
	output logic [`CSR_XLEN-1:0]   rdata,
	output logic                   illegal,
	output logic [`CSR_XLEN-1:0]   trap_addr,
	output logic                   trap_is_irq,
	output logic                   trap_enter_vld,
	input  logic                   trap_enter_rdy,
	input  logic [`CSR_XLEN-1:0]   mepc_in,
	input  logic                   delay_irq_entry,
	input  logic [`CSR_N_IRQ-1:0]  irq,
	input  csr_pkg::except_t       except,
	input  logic                   instr_ret
);

	import csr_pkg::*;

	csr_sel_t             sel;
	logic                 wr_en;
	logic [`CSR_XLEN-1:0] trap_rdata;
	logic [`CSR_XLEN-1:0] ctr_rdata;
	logic [`CSR_XLEN-1:0] mip;
	logic                 mstatus_mie;
	logic [`CSR_XLEN-1:0] mie;
	logic [`CSR_XLEN-1:0] mtvec;
	logic [`CSR_XLEN-1:0] mepc;
	logic                 trap_fire;
	trap_cause_t          trap_cause;

	// ----------------------------------------
	// Access path
	csr_decode i_csr_decode (
		.req        (req),
		.trap_rdata (trap_rdata),
		.ctr_rdata  (ctr_rdata),
		.mip        (mip),
		.sel        (sel),
		.wr_en      (wr_en),
		.rdata      (rdata),
		.illegal    (illegal)
	);

	csr_trap_regs i_csr_trap_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.sel         (sel),
		.wr_en       (wr_en),
		.trap_fire   (trap_fire),
		.trap_cause  (trap_cause),
		.except      (except),
		.mepc_in     (mepc_in),
		.trap_rdata  (trap_rdata),
		.mstatus_mie (mstatus_mie),
		.mie         (mie),
		.mtvec       (mtvec),
		.mepc        (mepc)
	);

	csr_counters i_csr_counters (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.sel       (sel),
		.wr_en     (wr_en),
		.instr_ret (instr_ret),
		.ctr_rdata (ctr_rdata)
	);

	// ----------------------------------------
	// Trap path
	csr_irq_ctrl i_csr_irq_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.irq             (irq),
		.delay_irq_entry (delay_irq_entry),
		.except          (except),
		.trap_enter_rdy  (trap_enter_rdy),
		.mstatus_mie     (mstatus_mie),
		.mie             (mie),
		.mtvec           (mtvec),
		.mepc            (mepc),
		.mip             (mip),
		.trap_addr       (trap_addr),
		.trap_is_irq     (trap_is_irq),
		.trap_enter_vld  (trap_enter_vld),
		.trap_fire       (trap_fire),
		.trap_cause      (trap_cause)
	);

endmodule

// ==== dv/tb_clkgen.sv ====
/*
 * Testbench clock source
 * Free-running clock, starts low
 */
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2) clk = ~clk; // Half period per phase

endmodule

// ==== dv/tb_csr_checker.sv ====
/*
 * Testbench checker for the CSR block
 * Samples DUT outputs on the rising edge and compares them with the
 * expectations of the current stimulus record
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_checker (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  chk_en,      // A record is being applied
	input  logic                  chk_rdata,   // Read data is meaningful for this record
	input  logic [8*16-1:0]       test_name,
	input  logic [`CSR_XLEN-1:0]  exp_rdata,
	input  logic                  exp_illegal,
	input  logic                  exp_vld,
	input  logic                  exp_is_irq,
	input  logic [`CSR_XLEN-1:0]  exp_taddr,
	input  logic [`CSR_XLEN-1:0]  rdata,
	input  logic                  illegal,
	input  logic                  trap_enter_vld,
	input  logic                  trap_is_irq,
	input  logic [`CSR_XLEN-1:0]  trap_addr,
	output int                    checks,
	output int                    errors
);

	initial begin
		checks = 0;
		errors = 0;
	end

	// One line per wrong value
	task automatic report_mismatch(
		input logic [8*16-1:0]      name,
		input logic [8*16-1:0]      what,
		input logic [`CSR_XLEN-1:0] expected,
		input logic [`CSR_XLEN-1:0] actual
	);
		errors++;
		$display("ERROR %0s %0s: expected %h, actual %h at %0t", name, what,
			expected, actual, $time);
	endtask

	// ----------------------------------------
	// Outputs are settled here, state updates land after this edge
	always @(posedge clk) begin
		if (rst_n && chk_en) begin
			checks++;
			if (chk_rdata && rdata !== exp_rdata)
				report_mismatch(test_name, "rdata", exp_rdata, rdata);
			if (illegal !== exp_illegal)
				report_mismatch(test_name, "illegal", exp_illegal, illegal);
			if (trap_enter_vld !== exp_vld)
				report_mismatch(test_name, "trap_enter_vld", exp_vld, trap_enter_vld);
			if (exp_vld && trap_addr !== exp_taddr) // Target only matters with a request
				report_mismatch(test_name, "trap_addr", exp_taddr, trap_addr);
			if (exp_vld && trap_is_irq !== exp_is_irq)
				report_mismatch(test_name, "trap_is_irq", exp_is_irq, trap_is_irq);
		end
	end

endmodule

// ==== dv/tb_csr_top.sv ====
/*
 * Testbench top for the CSR block
 * Reads stimulus records from a file, drives them on the falling edge
 * and hands the expected results to the checker
 */
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_top;

	import csr_pkg::*;

	localparam int RST_CYCLES    = 16;
	localparam int RST_TIMEOUT   = 32;     // Cycles for the DUT to go idle after reset
	localparam int MAX_RECORDS   = 500;
	localparam int DRAIN_TIMEOUT = 8;
	localparam int WATCHDOG_NS   = 200000;

	logic                  clk;
	logic                  rst_n;
	csr_req_t              req;
	logic [`CSR_XLEN-1:0]  rdata;
	logic                  illegal;
	logic [`CSR_XLEN-1:0]  trap_addr;
	logic                  trap_is_irq;
	logic                  trap_enter_vld;
	logic                  trap_enter_rdy;
	logic [`CSR_XLEN-1:0]  mepc_in;
	logic                  delay_irq_entry;
	logic [`CSR_N_IRQ-1:0] irq;
	except_t               except;
	logic                  instr_ret;

	// Checker side
	logic                  chk_en;
	logic                  chk_rdata;
	logic [8*16-1:0]       tname;
	logic [`CSR_XLEN-1:0]  exp_rdata;
	logic                  exp_illegal;
	logic                  exp_vld;
	logic                  exp_is_irq;
	logic [`CSR_XLEN-1:0]  exp_taddr;
	int                    n_checks;
	int                    n_errors;

	// Record fields as read from the file
	integer                fd;
	integer                code;
	int                    n_rec;
	int                    cnt;
	logic                  done;
	logic [8*8-1:0]        op;
	logic [8*16-1:0]       f_name;
	logic [8*256-1:0]      skip_line;
	logic [31:0]           f_addr, f_wdata, f_wtype, f_irq, f_except;
	logic [31:0]           f_rdy, f_iret, f_rdata, f_ill, f_vld, f_taddr;

	tb_clkgen #(.PERIOD_NS(100)) i_tb_clkgen (.clk(clk));

	csr_top i_csr_top (
		.clk             (clk),
		.rst_n           (rst_n),
		.req             (req),
		.rdata           (rdata),
		.illegal         (illegal),
		.trap_addr       (trap_addr),
		.trap_is_irq     (trap_is_irq),
		.trap_enter_vld  (trap_enter_vld),
		.trap_enter_rdy  (trap_enter_rdy),
		.mepc_in         (mepc_in),
		.delay_irq_entry (delay_irq_entry),
		.irq             (irq),
		.except          (except),
		.instr_ret       (instr_ret)
	);

	tb_csr_checker i_tb_csr_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.chk_en         (chk_en),
		.chk_rdata      (chk_rdata),
		.test_name      (tname),
		.exp_rdata      (exp_rdata),
		.exp_illegal    (exp_illegal),
		.exp_vld        (exp_vld),
		.exp_is_irq     (exp_is_irq),
		.exp_taddr      (exp_taddr),
		.rdata          (rdata),
		.illegal        (illegal),
		.trap_enter_vld (trap_enter_vld),
		.trap_is_irq    (trap_is_irq),
		.trap_addr      (trap_addr),
		.checks         (n_checks),
		.errors         (n_errors)
	);

	// ----------------------------------------
	// Drive helpers
	task automatic abort_run(input string why);
		$display("%0s", why);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic drive_idle();
		req             = '0;
		req.wtype       = wt_write;
		except          = exc_none;
		irq             = '0;
		trap_enter_rdy  = 1'b0;
		instr_ret       = 1'b0;
		mepc_in         = '0;
		delay_irq_entry = 1'b0;
		chk_en          = 1'b0;           // Nothing to compare
		chk_rdata       = 1'b0;
	endtask

	task automatic apply_record();
		req.addr       = f_addr[`CSR_ADDR_W-1:0];
		req.wdata      = f_wdata;
		req.wtype      = csr_wtype_t'(f_wtype[1:0]);
		req.ren        = (op == "rd") || (op == "wr");
		req.wen        = (op == "wr");
		mepc_in        = f_wdata;         // Only captured when a trap is taken
		irq            = f_irq[`CSR_N_IRQ-1:0];
		except         = except_t'(f_except[3:0]);
		trap_enter_rdy = f_rdy[0];
		instr_ret      = f_iret[0];
		tname          = f_name;
		exp_rdata      = f_rdata;
		exp_illegal    = f_ill[0];
		exp_vld        = f_vld[0];
		exp_is_irq     = (f_except[3:0] == 4'hf); // Exceptions outrank interrupts
		exp_taddr      = f_taddr;
		chk_rdata      = (op == "rd");
		chk_en         = 1'b1;
	endtask

	// Hard stop if the clock or a wait gets stuck
	initial begin
		#(WATCHDOG_NS);
		abort_run("Simulation ran past its time limit");
	end

	// ----------------------------------------
	// Main sequence
	initial begin
		drive_idle();
		tname = "reset";
		{exp_rdata, exp_illegal, exp_vld, exp_is_irq, exp_taddr} = '0;
		rst_n = 1'b0;
		cnt   = 0;
		while (cnt < RST_CYCLES) begin
			@(negedge clk);
			cnt++;
		end
		rst_n = 1'b1;

		// Idle outputs after reset
		cnt = 0;
		while ((illegal !== 1'b0 || trap_enter_vld !== 1'b0) && cnt < RST_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (illegal !== 1'b0 || trap_enter_vld !== 1'b0)
			abort_run("DUT did not reach its idle state after reset");

		fd = $fopen("dv/csr_stim.txt", "r");
		if (fd == 0)
			abort_run("Cannot open stimulus file dv/csr_stim.txt");

		n_rec = 0;
		done  = 1'b0;
		while (!done && n_rec < MAX_RECORDS) begin
			code = $fscanf(fd, "%s", op);
			if (code != 1) begin
				done = 1'b1;                    // End of file
			end else if (op == "#") begin
				code = $fgets(skip_line, fd);   // Comment line
			end else begin
				code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h", f_name,
					f_addr, f_wdata, f_wtype, f_irq, f_except, f_rdy, f_iret,
					f_rdata, f_ill, f_vld, f_taddr);
				if (code != 12) begin
					abort_run("Malformed record in stimulus file");
				end else if (op != "rd" && op != "wr" && op != "nop") begin
					abort_run("Unknown operation in stimulus file");
				end else begin
					@(negedge clk);
					apply_record();
					n_rec++;
				end
			end
		end
		$fclose(fd);
		if (!done)
			abort_run("Stimulus file did not end within the record limit");

		// Let the checker see the last record
		cnt = 0;
		while (n_checks < n_rec && cnt < DRAIN_TIMEOUT) begin
			@(negedge clk);
			drive_idle();
			cnt++;
		end
		if (n_checks < n_rec)
			abort_run("Checker did not see every stimulus record");

		$display("Records: %0d, checks: %0d, errors: %0d", n_rec, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/csr_stim.txt ====
# op name addr wdata wtype irq except rdy iret exp_rdata exp_illegal exp_vld exp_trap_addr
# exp_rdata checked on rd only, exp_trap_addr only when exp_vld is 1, wdata is also mepc_in
wr  ms_write      340 a5a50f0f 1 0000 f 0 0 00000000 0 0 00000000
rd  ms_rd1        340 00000000 1 0000 f 0 0 a5a50f0f 0 0 00000000
wr  ms_set        340 0000f0f0 2 0000 f 0 0 00000000 0 0 00000000
rd  ms_rd2        340 00000000 1 0000 f 0 0 a5a5ffff 0 0 00000000
wr  ms_clear      340 a5a50000 3 0000 f 0 0 00000000 0 0 00000000
rd  ms_rd3        340 00000000 1 0000 f 0 0 0000ffff 0 0 00000000
wr  mie_write     304 ffffffff 1 0000 f 0 0 00000000 0 0 00000000
rd  mie_rd1       304 00000000 1 0000 f 0 0 ffff0888 0 0 00000000
wr  mie_clear     304 0000ffff 3 0000 f 0 0 00000000 0 0 00000000
rd  mie_rd2       304 00000000 1 0000 f 0 0 ffff0000 0 0 00000000
wr  mie_set       304 00000800 2 0000 f 0 0 00000000 0 0 00000000
rd  mie_rd3       304 00000000 1 0000 f 0 0 ffff0800 0 0 00000000
wr  mtvec_write   305 00001003 1 0000 f 0 0 00000000 0 0 00000000
rd  mtvec_rd1     305 00000000 1 0000 f 0 0 00001001 0 0 00000000
wr  mtvec_clear   305 00000001 3 0000 f 0 0 00000000 0 0 00000000
rd  mtvec_rd2     305 00000000 1 0000 f 0 0 00001000 0 0 00000000
# identity registers and illegal accesses
rd  misa_rd       301 00000000 1 0000 f 0 0 40001104 0 0 00000000
rd  mvendorid_rd  f11 00000000 1 0000 f 0 0 00000000 0 0 00000000
rd  marchid_rd    f12 00000000 1 0000 f 0 0 0000001b 0 0 00000000
rd  mimpid_rd     f13 00000000 1 0000 f 0 0 00000001 0 0 00000000
rd  mhartid_rd    f14 00000000 1 0000 f 0 0 00000000 0 0 00000000
rd  mtval_rd      343 00000000 1 0000 f 0 0 00000000 0 0 00000000
rd  hpm3_rd       b03 00000000 1 0000 f 0 0 00000000 1 0 00000000
wr  mvendorid_wr  f11 ffffffff 1 0000 f 0 0 00000000 1 0 00000000
wr  misa_wr       301 00000000 1 0000 f 0 0 00000000 0 0 00000000
# counters with and without inhibit
wr  inhibit_set   320 00000005 1 0000 f 0 0 00000000 0 0 00000000
wr  mcycle_wr     b00 00000100 1 0000 f 0 0 00000000 0 0 00000000
wr  minstret_wr   b02 00000200 1 0000 f 0 1 00000000 0 0 00000000
rd  mcycle_rd     b00 00000000 1 0000 f 0 1 00000100 0 0 00000000
rd  minstret_rd   b02 00000000 1 0000 f 0 1 00000200 0 0 00000000
rd  minstreth_rd  b82 00000000 1 0000 f 0 0 00000000 0 0 00000000
wr  inhibit_clr   320 00000005 3 0000 f 0 0 00000000 0 0 00000000
rd  instret_a     b02 00000000 1 0000 f 0 1 00000200 0 0 00000000
rd  instret_b     b02 00000000 1 0000 f 0 1 00000201 0 0 00000000
rd  instret_c     b02 00000000 1 0000 f 0 0 00000202 0 0 00000000
rd  instret_d     b02 00000000 1 0000 f 0 1 00000202 0 0 00000000
rd  instret_e     b02 00000000 1 0000 f 0 0 00000203 0 0 00000000
# exception entry and mret
wr  mstatus_set   300 00000008 2 0000 f 0 0 00000000 0 0 00000000
rd  mstatus_rd1   300 00000000 1 0000 f 0 0 00001808 0 0 00000000
nop exc_wait      000 00001235 1 0000 2 0 0 00000000 0 1 00001000
nop exc_take      000 00001235 1 0000 2 1 0 00000000 0 1 00001000
rd  mcause_rd     342 00000000 1 0000 f 0 0 00000002 0 0 00000000
rd  mepc_rd       341 00000000 1 0000 f 0 0 00001234 0 0 00000000
rd  mstatus_rd2   300 00000000 1 0000 f 0 0 00001880 0 0 00000000
nop mret_wait     000 00000000 1 0000 a 0 0 00000000 0 1 00001234
nop mret_take     000 00000000 1 0000 a 1 0 00000000 0 1 00001234
rd  mstatus_rd3   300 00000000 1 0000 f 0 0 00001888 0 0 00000000
# vectored interrupts, priority and masking
wr  mtvec_vec     305 00000001 2 0000 f 0 0 00000000 0 0 00000000
nop irq5_raise    000 00000000 1 0020 f 0 0 00000000 0 0 00000000
nop irq5_req      000 00000000 1 0020 f 0 0 00000000 0 1 00001054
nop irq2_raise    000 00000000 1 0024 f 0 0 00000000 0 1 00001054
rd  mip_rd        344 00000000 1 0024 f 0 0 00240800 0 1 00001048
wr  mie_mask      304 00240000 3 0024 f 0 0 00000000 0 1 00001048
nop irq_masked    000 00000000 1 0024 f 0 0 00000000 0 0 00000000

// ==== flist.f ====
+incdir+include
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_trap_regs.sv
hw/csr_counters.sv
hw/csr_irq_ctrl.sv
hw/csr_top.sv
dv/tb_clkgen.sv
dv/tb_csr_checker.sv
dv/tb_csr_top.sv
